/* build.f */
corePkg.sv
fetchUnit.sv
loadStoreUnit.sv
memArbiter.sv
execUnit.sv
core.sv
core_props.sv
tbClock.sv
core_tb.sv

/* core.sv */
/*
 * Core top: fetch, load/store, arbiter and execute units on one memory port,
 * plus the debug PC and halted flag.
 */
`timescale 1ns/1ns
`default_nettype none

module core import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	output logic memValid,
	input wire memReady,
	output logic memWrite,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWData,
	input wire memRespValid,
	input wire [dataWidth-1:0] memRespData,
	output logic halted,
	output logic [dataWidth-1:0] debugPc
);

	// Fetch side
	logic fetchValid, fetchReady, fetchRespValid;
	logic [dataWidth-1:0] fetchAddr;
	logic instrValid, instrTake, redirect;
	logic [dataWidth-1:0] instrData, redirectPc;

	// Load/store side
	logic lsuValid, lsuReady, lsuWrite, lsuRespValid;
	logic [dataWidth-1:0] lsuAddr, lsuWData;
	logic cmdValid, cmdReady, cmdWrite, loadValid;
	logic [dataWidth-1:0] cmdAddr, cmdData, loadData;

	fetchUnit fetchInst (
		.iCLOCK(iCLOCK), .rstN(rstN),
		.fetchValid(fetchValid), .fetchReady(fetchReady), .fetchAddr(fetchAddr),
		.fetchRespValid(fetchRespValid), .respData(memRespData),
		.instrValid(instrValid), .instrData(instrData), .instrTake(instrTake),
		.redirect(redirect), .redirectPc(redirectPc), .halt(halted)
	);

	loadStoreUnit lsuInst (
		.iCLOCK(iCLOCK), .rstN(rstN),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdWrite(cmdWrite),
		.cmdAddr(cmdAddr), .cmdData(cmdData),
		.lsuValid(lsuValid), .lsuReady(lsuReady), .lsuWrite(lsuWrite),
		.lsuAddr(lsuAddr), .lsuWData(lsuWData),
		.lsuRespValid(lsuRespValid), .respData(memRespData),
		.loadValid(loadValid), .loadData(loadData)
	);

	// Both response paths share memRespData, only the valids are split
	memArbiter arbInst (
		.iCLOCK(iCLOCK), .rstN(rstN),
		.fetchValid(fetchValid), .fetchReady(fetchReady), .fetchAddr(fetchAddr),
		.fetchRespValid(fetchRespValid),
		.lsuValid(lsuValid), .lsuReady(lsuReady), .lsuWrite(lsuWrite),
		.lsuAddr(lsuAddr), .lsuWData(lsuWData), .lsuRespValid(lsuRespValid),
		.memValid(memValid), .memReady(memReady), .memWrite(memWrite),
		.memAddr(memAddr), .memWData(memWData), .memRespValid(memRespValid)
	);

	execUnit execInst (
		.iCLOCK(iCLOCK), .rstN(rstN),
		.instrValid(instrValid), .instrData(instrData), .instrTake(instrTake),
		.redirect(redirect), .redirectPc(redirectPc),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdWrite(cmdWrite),
		.cmdAddr(cmdAddr), .cmdData(cmdData),
		.loadValid(loadValid), .loadData(loadData),
		.halted(halted), .debugPc(debugPc)
	);

endmodule

`default_nettype wire

/* corePkg.sv */
/*
 * Shared definitions for the small core: widths, opcodes, the instruction
 * word layout and the arbiter owner codes. Modules pull it in by wildcard import.
 */
`default_nettype none

package corePkg;

	// Word, address and PC width
	localparam int dataWidth = 32;

	// Register file
	localparam int regCount = 16;
	localparam int regIdxWidth = 4;

	// Instruction field widths
	localparam int opWidth = 4;
	localparam int immWidth = 20;
	localparam int regPadWidth = 16;

	// Opcodes, anything else runs as HALT
	localparam logic [opWidth-1:0] opAdd = 4'h1;
	localparam logic [opWidth-1:0] opSub = 4'h2;
	localparam logic [opWidth-1:0] opAnd = 4'h3;
	localparam logic [opWidth-1:0] opAddi = 4'h4;
	localparam logic [opWidth-1:0] opLd = 4'h5;
	localparam logic [opWidth-1:0] opSt = 4'h6;
	localparam logic [opWidth-1:0] opBeq = 4'h7;
	localparam logic [opWidth-1:0] opHalt = 4'hF;

	// Arbiter owner codes
	localparam logic reqFetch = 1'b0;
	localparam logic reqLsu = 1'b1;

	// PC after reset, in words
	localparam logic [dataWidth-1:0] resetPc = '0;

	// Same 32 bits, two decodings
	typedef union packed {
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regIdxWidth-1:0] rd;
			logic [regIdxWidth-1:0] ra;
			logic [regIdxWidth-1:0] rb;
			logic [regPadWidth-1:0] unused;
		} regForm;
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regIdxWidth-1:0] rd;
			logic [regIdxWidth-1:0] ra;
			// Sign-extended at use
			logic [immWidth-1:0] imm;
		} immForm;
	} instrWord;

endpackage

`default_nettype wire

/* core_props.sv */
/*
 * Concurrent checks on the memory port and the arbiter, bound into
 * memArbiter so they can see the port, the LSU request and the owner register.
 */
`timescale 1ns/1ns
`default_nettype none

module core_props import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	input wire memValid,
	input wire memReady,
	input wire memWrite,
	input wire [dataWidth-1:0] memAddr,
	input wire [dataWidth-1:0] memWData,
	input wire memRespValid,
	input wire lsuValid,
	input wire owner
);

	// Read taken by the port and its response not back yet
	logic readOpen;

	always_ff @(posedge iCLOCK or negedge rstN) begin
		if (!rstN)
			readOpen <= 1'b0;
		else if (memValid && memReady && !memWrite)
			readOpen <= 1'b1;
		else if (memRespValid)
			readOpen <= 1'b0;
	end

	// Stalled request holds address, direction and store data
	stalledStable: assert property (@(posedge iCLOCK) disable iff (!rstN)
		(memValid && !memReady) |=> (memValid && $stable(memAddr) && $stable(memWrite)
			&& (!memWrite || $stable(memWData))))
		else $error("memory request changed while stalled");

	// No new grant while a read is outstanding
	noGrantBusy: assert property (@(posedge iCLOCK) disable iff (!rstN)
		readOpen |-> !memValid)
		else $error("request granted while a read was outstanding");

	// LSU wins any grant that is not a held stall
	lsuFirst: assert property (@(posedge iCLOCK) disable iff (!rstN)
		(memValid && lsuValid && !$past(memValid && !memReady)) |=> (owner == reqLsu))
		else $error("fetch granted over a waiting load/store");

	idleInReset: assert property (@(posedge iCLOCK) !rstN |-> !memValid)
		else $error("memValid high during reset");

endmodule

bind memArbiter core_props propsInst (
	.iCLOCK(iCLOCK), .rstN(rstN),
	.memValid(memValid), .memReady(memReady), .memWrite(memWrite),
	.memAddr(memAddr), .memWData(memWData), .memRespValid(memRespValid),
	.lsuValid(lsuValid), .owner(owner)
);

`default_nettype wire

/* core_tb.sv */
/*
 * Testbench for the core. Loads each program from the tests file, serves the
 * memory port with optional random stalls, and checks stores, halt and final PC.
 */
`timescale 1ns/1ns
`default_nettype none

module core_tb import corePkg::*; ();

	localparam int memAddrBits = 8;
	localparam int memWords = 1 << memAddrBits;
	localparam int dataDepth = 512;
	localparam int clockPeriod = 10;
	localparam int resetCycles = 16;
	// Worst case per instruction, flushed refetch plus a stalled load
	localparam int cyclesPerInstr = 64;
	localparam int quietCycles = 16;
	localparam logic [31:0] lfsrSeed = 32'he5be_7bae;

	logic clk;
	logic rstN;
	logic resetReq = 1'b0;
	logic memValid;
	logic memWrite;
	logic memReady = 1'b0;
	logic memRespValid = 1'b0;
	logic halted;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWData;
	logic [dataWidth-1:0] memRespData = '0;
	logic [dataWidth-1:0] debugPc;

	// Raw words of the tests file
	logic [31:0] testData [dataDepth];
	logic [31:0] mem [memWords];
	logic [31:0] lfsrState = lfsrSeed;
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int errorCount = 0;
	int ptr;
	int numTests;
	int curTest;
	int watchdogNs;
	logic loaded = 1'b0;
	logic stallMode = 1'b0;
	// Read response still owed by the memory model
	logic respPending = 1'b0;
	int respCount;
	logic [31:0] respWord;

	tbClock clockGen (.clk(clk), .rstN(rstN), .resetReq(resetReq));

	core dut_i (
		.iCLOCK(clk), .rstN(rstN),
		.memValid(memValid), .memReady(memReady), .memWrite(memWrite),
		.memAddr(memAddr), .memWData(memWData),
		.memRespValid(memRespValid), .memRespData(memRespData),
		.halted(halted), .debugPc(debugPc)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic int takeBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | int'(lfsrState[0]);
		end
		return v;
	endfunction

	// Top nibble is an undefined opcode, so stray fetches halt
	function automatic logic [31:0] fillWord(input logic [31:0] a);
		return 32'hA5A5_0000 ^ a;
	endfunction

	function automatic logic [31:0] nextWord();
		logic [31:0] w;
		w = testData[ptr];
		ptr++;
		return w;
	endfunction

	task automatic checkStore(input logic [31:0] a, input logic [31:0] d);
		logic [31:0] wantAddr;
		logic [31:0] wantData;
		if (expAddr.size() == 0) begin
			$display("Test %0d made a store to 0x%08h that no rule calls for", curTest, a);
			errorCount++;
		end else begin
			wantAddr = expAddr.pop_front();
			wantData = expData.pop_front();
			if (a != wantAddr || d != wantData) begin
				$display("ERROR %0t ns: test %0d stored 0x%08h at 0x%08h, expected 0x%08h at 0x%08h",
					$time, curTest, d, a, wantData, wantAddr);
				errorCount++;
			end
		end
	endtask

	// Memory model, one read answered at a time
	always @(posedge clk) begin
		if (!rstN) begin
			memReady <= 1'b0;
			memRespValid <= 1'b0;
			respPending = 1'b0;
		end else begin
			memRespValid <= 1'b0;
			if (memValid && memReady) begin
				if (memAddr >= memWords) begin
					$display("Test %0d accessed address 0x%08h outside the memory", curTest, memAddr);
					errorCount++;
				end
				if (memWrite) begin
					checkStore(memAddr, memWData);
					if (memAddr < memWords)
						mem[memAddr[memAddrBits-1:0]] = memWData;
				end else begin
					respWord = (memAddr < memWords) ? mem[memAddr[memAddrBits-1:0]] : fillWord(memAddr);
					// Zero to three extra cycles of response delay
					respCount = stallMode ? takeBits(2) : 0;
					if (respCount == 0) begin
						memRespValid <= 1'b1;
						memRespData <= respWord;
					end else begin
						respPending = 1'b1;
					end
				end
			end else if (respPending) begin
				respCount--;
				if (respCount == 0) begin
					memRespValid <= 1'b1;
					memRespData <= respWord;
					respPending = 1'b0;
				end
			end
			// Back-pressure on about a quarter of the cycles
			memReady <= stallMode ? (takeBits(2) != 0) : 1'b1;
		end
	end

	task automatic runTest();
		logic [31:0] mode;
		logic [31:0] count;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] finalPc;
		mode = nextWord();
		// Executed count only sizes the watchdog
		void'(nextWord());
		@(posedge clk);
		resetReq <= 1'b1;
		@(posedge clk);
		resetReq <= 1'b0;
		stallMode = mode[0];
		// Image goes in while the core is held in reset
		for (int i = 0; i < memWords; i++)
			mem[i] = fillWord(i);
		count = nextWord();
		for (int i = 0; i < int'(count); i++) begin
			a = nextWord();
			d = nextWord();
			mem[a[memAddrBits-1:0]] = d;
		end
		expAddr.delete();
		expData.delete();
		count = nextWord();
		for (int i = 0; i < int'(count); i++) begin
			expAddr.push_back(nextWord());
			expData.push_back(nextWord());
		end
		finalPc = nextWord();
		// Through reset and the first edge out of it
		do begin
			@(posedge clk);
			if (memValid || halted) begin
				$display("Test %0d saw memValid or halted high around reset at %0t ns", curTest, $time);
				errorCount++;
			end
		end while (!rstN);
		while (!halted)
			@(posedge clk);
		if (debugPc != finalPc) begin
			$display("ERROR %0t ns: test %0d halted at PC 0x%08h, expected 0x%08h",
				$time, curTest, debugPc, finalPc);
			errorCount++;
		end
		// Port must stay quiet after HALT
		for (int i = 0; i < quietCycles; i++) begin
			if (memValid || !halted) begin
				$display("Test %0d: core made a request or left halt at %0t ns", curTest, $time);
				errorCount++;
			end
			@(posedge clk);
		end
		if (expAddr.size() != 0) begin
			$display("Test %0d halted with %0d expected stores never made", curTest, expAddr.size());
			errorCount++;
		end
	endtask

	initial begin
		int totalExec;
		int scan;
		$readmemh("core_tests.txt", testData);
		numTests = int'(testData[0]);
		// Walk the records once to size the watchdog
		totalExec = 0;
		scan = 1;
		for (int t = 0; t < numTests; t++) begin
			totalExec += int'(testData[scan + 1]);
			scan += 2;
			scan += 1 + 2 * int'(testData[scan]);
			scan += 1 + 2 * int'(testData[scan]);
			scan += 1;
		end
		watchdogNs = clockPeriod * (totalExec * cyclesPerInstr
			+ numTests * (resetCycles + quietCycles + 4));
		loaded = 1'b1;
		ptr = 1;
		for (curTest = 1; curTest <= numTests; curTest++)
			runTest();
		$display("Ran %0d tests with %0d errors", numTests, errorCount);
		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial begin
		wait (loaded);
		#(watchdogNs);
		$display("Timeout: the core never halted within %0d ns", watchdogNs);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* core_tests.txt */
// Hex words. Test count, then per test: stall mode, executed instruction count,
// image pair count, address/word pairs, store count, address/data pairs, final PC
3

// Test 1: ALU forms, memory always ready
0 A
A
0 41000036  // ADDI r1, r0, 0x36
1 420FFFFD  // ADDI r2, r0, -3
2 13120000  // ADD r3, r1, r2
3 24120000  // SUB r4, r1, r2
4 35120000  // AND r5, r1, r2
5 63000040  // ST r3, [r0+0x40]
6 64000041  // ST r4, [r0+0x41]
7 65000042  // ST r5, [r0+0x42]
8 62000043  // ST r2, [r0+0x43]
9 F0000000  // HALT
4
40 00000033  41 00000039  42 00000034  43 FFFFFFFD
9

// Test 2: loads and r0, random stalls
1 C
E
0 51000020  // LD r1, [r0+0x20]
1 46000010  // ADDI r6, r0, 0x10
2 52600011  // LD r2, [r6+0x11]
3 40100007  // ADDI r0, r1, 7 (discarded)
4 13120000  // ADD r3, r1, r2
5 61000030  // ST r1, [r0+0x30]
6 60000031  // ST r0, [r0+0x31]
7 63000032  // ST r3, [r0+0x32]
8 54000031  // LD r4, [r0+0x31]
9 44400001  // ADDI r4, r4, 1
A 64000033  // ST r4, [r0+0x33]
B F0000000  // HALT
20 12345678  21 CAFEF00D
4
30 12345678  31 00000000  32 DD334685  33 00000001
B

// Test 3: BEQ taken and not taken, countdown loop, random stalls
1 11
C
0 41000003  // ADDI r1, r0, 3
1 42000003  // ADDI r2, r0, 3
2 71200002  // BEQ r1, r2, +2 taken
3 61000050  // ST r1, [r0+0x50] skipped
4 61000051  // ST r1, [r0+0x51] skipped
5 71000001  // BEQ r1, r0, +1 not taken
6 62000052  // ST r2, [r0+0x52]
7 411FFFFF  // ADDI r1, r1, -1
8 61000053  // ST r1, [r0+0x53]
9 71000001  // BEQ r1, r0, +1 exits at zero
A 700FFFFC  // BEQ r0, r0, -4 back to 7
B F0000000  // HALT
4
52 00000003  53 00000002  53 00000001  53 00000000
B

/* execUnit.sv */
/*
 * Execute unit: decodes the buffered instruction, runs ALU ops and
 * branches in one cycle, and waits on the load/store unit for memory ops.
 */
`timescale 1ns/1ns
`default_nettype none

module execUnit import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	input wire instrValid,
	input wire [dataWidth-1:0] instrData,
	output logic instrTake,
	output logic redirect,
	output logic [dataWidth-1:0] redirectPc,
	output logic cmdValid,
	input wire cmdReady,
	output logic cmdWrite,
	output logic [dataWidth-1:0] cmdAddr,
	output logic [dataWidth-1:0] cmdData,
	input wire loadValid,
	input wire [dataWidth-1:0] loadData,
	output logic halted,
	output logic [dataWidth-1:0] debugPc
);

	instrWord instr;
	logic [opWidth-1:0] opcode;
	logic isRegOp, isAddi, isLoad, isStore, isBeq, isMem, isAluWrite, isHalt;
	logic [regIdxWidth-1:0] rdIdx, raIdx, rbIdx;
	logic [dataWidth-1:0] rdVal, raVal, rbVal, immExt, aluResult;
	logic [dataWidth-1:0] regFile [regCount];
	logic [dataWidth-1:0] pc;
	logic memWait;
	logic memIsLoad;
	logic memDone;
	logic [regIdxWidth-1:0] loadRd;
	logic run;
	logic wbEn;
	logic [regIdxWidth-1:0] wbIdx;
	logic [dataWidth-1:0] wbData;

	assign instr = instrData;
	// Opcode sits in the same bits for both formats
	assign opcode = instr.regForm.opcode;

	assign isRegOp = (opcode == opAdd) || (opcode == opSub) || (opcode == opAnd);
	assign isAddi = (opcode == opAddi);
	assign isLoad = (opcode == opLd);
	assign isStore = (opcode == opSt);
	assign isBeq = (opcode == opBeq);
	assign isMem = isLoad || isStore;
	assign isAluWrite = isRegOp || isAddi;
	// opHalt and all undefined codes
	assign isHalt = !(isAluWrite || isMem || isBeq);

	// rd and ra share their bits in both views
	assign rdIdx = instr.regForm.rd;
	assign raIdx = instr.regForm.ra;
	// rb only exists in the register form
	assign rbIdx = isRegOp ? instr.regForm.rb : '0;
	assign immExt = {{(dataWidth-immWidth){instr.immForm.imm[immWidth-1]}}, instr.immForm.imm};

	// r0 is hardwired to zero
	assign rdVal = (rdIdx == '0) ? '0 : regFile[rdIdx];
	assign raVal = (raIdx == '0) ? '0 : regFile[raIdx];
	assign rbVal = (rbIdx == '0) ? '0 : regFile[rbIdx];

	always_comb begin
		case (opcode)
			opAdd: aluResult = raVal + rbVal;
			opSub: aluResult = raVal - rbVal;
			opAnd: aluResult = raVal & rbVal;
			default: aluResult = raVal + immExt;
		endcase
	end

	// Ready to act on the buffered word
	assign run = instrValid && !memWait && !halted;

	assign redirect = run && isBeq && (rdVal == raVal);
	// Target relative to the next word
	assign redirectPc = pc + 1'b1 + immExt;

	// HALT stays in the buffer so fetch stops
	assign instrTake = run && (isAluWrite || isBeq || (isMem && cmdReady));

	assign cmdValid = run && isMem;
	assign cmdWrite = isStore;
	assign cmdAddr = raVal + immExt;
	assign cmdData = rdVal;

	// Loads finish on the data, stores when the LSU frees up
	assign memDone = memIsLoad ? loadValid : cmdReady;

	always_comb begin
		if (memWait && memIsLoad) begin
			wbEn = loadValid;
			wbIdx = loadRd;
			wbData = loadData;
		end else begin
			wbEn = run && isAluWrite;
			wbIdx = rdIdx;
			wbData = aluResult;
		end
	end

	assign debugPc = pc;

	always_ff @(posedge iCLOCK or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			memWait <= 1'b0;
			memIsLoad <= 1'b0;
			halted <= 1'b0;
		end else if (run) begin
			if (isHalt)
				halted <= 1'b1;
			else if (instrTake)
				pc <= redirect ? redirectPc : pc + 1'b1;
			if (isMem && cmdReady) begin
				memWait <= 1'b1;
				memIsLoad <= isLoad;
			end
		end else if (memWait && memDone) begin
			memWait <= 1'b0;
		end
	end

	// Register file and load destination
	always_ff @(posedge iCLOCK) begin
		if (wbEn && (wbIdx != '0))
			regFile[wbIdx] <= wbData;
		if (run && isLoad && cmdReady)
			loadRd <= rdIdx;
	end

endmodule

`default_nettype wire

/* fetchUnit.sv */
/*
 * Instruction fetch with a one-entry buffer; prefetches the next word
 * while the execute unit consumes the current one, and flushes on redirect.
 */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	output logic fetchValid,
	input wire fetchReady,
	output logic [dataWidth-1:0] fetchAddr,
	input wire fetchRespValid,
	input wire [dataWidth-1:0] respData,
	output logic instrValid,
	output logic [dataWidth-1:0] instrData,
	input wire instrTake,
	input wire redirect,
	input wire [dataWidth-1:0] redirectPc,
	input wire halt
);

	logic reqActive;
	logic waitResp;
	logic dropResp;
	logic bufValid;
	logic [dataWidth-1:0] bufData;
	logic [dataWidth-1:0] reqAddr;
	logic [dataWidth-1:0] fetchPc;
	logic outstanding;
	logic issue;

	// Request issued but not yet answered
	assign outstanding = reqActive || waitResp;
	// Start a fetch once the buffer is free or being popped this cycle
	assign issue = !outstanding && (!bufValid || instrTake) && !halt;

	assign fetchValid = reqActive;
	// Held in its own register so a redirect cannot move a stalled request
	assign fetchAddr = reqAddr;
	assign instrValid = bufValid;
	assign instrData = bufData;

	always_ff @(posedge iCLOCK or negedge rstN) begin
		if (!rstN) begin
			reqActive <= 1'b0;
			waitResp <= 1'b0;
			dropResp <= 1'b0;
			bufValid <= 1'b0;
			fetchPc <= resetPc;
		end else begin
			if (issue) begin
				reqActive <= 1'b1;
				fetchPc <= fetchPc + 1'b1;
			end
			if (reqActive && fetchReady) begin
				reqActive <= 1'b0;
				waitResp <= 1'b1;
			end
			if (instrTake)
				bufValid <= 1'b0;
			if (fetchRespValid) begin
				waitResp <= 1'b0;
				// Stale word from before a redirect is thrown away
				if (dropResp)
					dropResp <= 1'b0;
				else
					bufValid <= 1'b1;
			end
			// Flush wins over everything above
			if (redirect) begin
				fetchPc <= redirectPc;
				bufValid <= 1'b0;
				// Fall-through word fetched alongside the branch is dropped too
				dropResp <= issue || reqActive || (waitResp && !fetchRespValid);
			end
		end
	end

	// Payload only
	always_ff @(posedge iCLOCK) begin
		if (issue)
			reqAddr <= fetchPc;
		if (fetchRespValid)
			bufData <= respData;
	end

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
/*
 * Load/store unit: takes one command from the execute unit, puts it on
 * the bus and waits for completion before accepting another.
 */
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	input wire cmdValid,
	output logic cmdReady,
	input wire cmdWrite,
	input wire [dataWidth-1:0] cmdAddr,
	input wire [dataWidth-1:0] cmdData,
	output logic lsuValid,
	input wire lsuReady,
	output logic lsuWrite,
	output logic [dataWidth-1:0] lsuAddr,
	output logic [dataWidth-1:0] lsuWData,
	input wire lsuRespValid,
	input wire [dataWidth-1:0] respData,
	output logic loadValid,
	output logic [dataWidth-1:0] loadData
);

	logic busy;
	logic reqOn;
	logic writeReg;
	logic [dataWidth-1:0] addrReg;
	logic [dataWidth-1:0] dataReg;

	assign cmdReady = !busy;
	assign lsuValid = reqOn;
	assign lsuWrite = writeReg;
	assign lsuAddr = addrReg;
	assign lsuWData = dataReg;
	// Response belongs to a pending read
	assign loadValid = lsuRespValid && busy && !writeReg;
	assign loadData = respData;

	always_ff @(posedge iCLOCK or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			reqOn <= 1'b0;
			writeReg <= 1'b0;
		end else begin
			if (cmdValid && !busy) begin
				busy <= 1'b1;
				reqOn <= 1'b1;
				writeReg <= cmdWrite;
			end
			if (reqOn && lsuReady) begin
				reqOn <= 1'b0;
				// A store is done at its transfer
				if (writeReg)
					busy <= 1'b0;
			end
			if (loadValid)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (cmdValid && !busy) begin
			addrReg <= cmdAddr;
			dataReg <= cmdData;
		end
	end

endmodule

`default_nettype wire

/* memArbiter.sv */
/*
 * Fixed-priority arbiter for the shared memory port; the load/store unit
 * beats fetch, one request outstanding, responses routed back by owner.
 */
`timescale 1ns/1ns
`default_nettype none

module memArbiter import corePkg::*; (
	input wire iCLOCK,
	input wire rstN,
	input wire fetchValid,
	output logic fetchReady,
	input wire [dataWidth-1:0] fetchAddr,
	output logic fetchRespValid,
	input wire lsuValid,
	output logic lsuReady,
	input wire lsuWrite,
	input wire [dataWidth-1:0] lsuAddr,
	input wire [dataWidth-1:0] lsuWData,
	output logic lsuRespValid,
	output logic memValid,
	input wire memReady,
	output logic memWrite,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWData,
	input wire memRespValid
);

	// Read in flight
	logic busy;
	logic owner;
	// Last cycle's request stalled, keep its owner
	logic stallHold;
	logic selOwner;

	assign selOwner = stallHold ? owner : (lsuValid ? reqLsu : reqFetch);

	// Grant is same-cycle, no register on the request path
	assign memValid = !busy && ((selOwner == reqLsu) ? lsuValid : fetchValid);
	assign memWrite = (selOwner == reqLsu) && lsuWrite;
	assign memAddr = (selOwner == reqLsu) ? lsuAddr : fetchAddr;
	// Fetch never writes
	assign memWData = lsuWData;

	assign fetchReady = !busy && (selOwner == reqFetch) && memReady;
	assign lsuReady = !busy && (selOwner == reqLsu) && memReady;

	assign fetchRespValid = memRespValid && busy && (owner == reqFetch);
	assign lsuRespValid = memRespValid && busy && (owner == reqLsu);

	always_ff @(posedge iCLOCK or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			owner <= reqFetch;
			stallHold <= 1'b0;
		end else begin
			if (memValid)
				owner <= selOwner;
			stallHold <= memValid && !memReady;
			// Writes finish at the transfer, reads wait for the response
			if (memValid && memReady && !memWrite)
				busy <= 1'b1;
			else if (memRespValid)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and judge the result from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f build.f -o core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	exit 0
fi
exit 1

/* tbClock.sv */
/*
 * Testbench clock and reset. 10 ns clock, rstN held low for 16 cycles at
 * time zero and again whenever resetReq is seen on a rising edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tbClock (
	output logic clk,
	output logic rstN,
	input wire resetReq
);

	localparam int halfPeriod = 5;
	localparam int resetCycles = 16;

	int holdCount;

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		holdCount = resetCycles;
	end

	always #halfPeriod clk = ~clk;

	always @(posedge clk) begin
		if (resetReq) begin
			rstN <= 1'b0;
			holdCount <= resetCycles;
		end else if (holdCount != 0) begin
			holdCount <= holdCount - 1;
			// Release on the last counted edge
			if (holdCount == 1)
				rstN <= 1'b1;
		end
	end

endmodule

`default_nettype wire
